//--- logic/predictor_pkg.sv
package predictor_pkg;

   // JTB geometry, one entry per instruction word slot
   localparam int JTB_ENTRIES  = 8;                 // entries in the jump target buffer
   localparam int JTB_INDEX_W  = $clog2(JTB_ENTRIES); // index bits taken from the word address

   // top address bits are not compared at all
   localparam int JTB_SHARED   = 8;                 // high bits dropped from the tag

   // tag covers what is left above the index and the byte offset
   localparam int JTB_TAG_W    = 32 - JTB_INDEX_W - 2 - JTB_SHARED;

   localparam int JTB_OFFSET_W = 20;                // jump offset in halfwords, signed

   // entry word is {tag, ualigc, offset}
   localparam int JTB_ENTRY_W  = JTB_TAG_W + 1 + JTB_OFFSET_W;

endpackage

//--- logic/rv_instr_pkg.sv
package rv_instr_pkg;

   localparam logic [6:0] OPC_JAL     = 7'b1101111; // JAL major opcode
   localparam logic [2:0] CJ_FUNCT3   = 3'b101;     // C.J funct3
   localparam logic [1:0] CJ_QUADRANT = 2'b01;      // C.J sits in quadrant 1
   localparam logic [1:0] QUAD_FULL   = 2'b11;      // low bits of a 32-bit instr

   // JAL, J-type immediate split over the word
   typedef struct packed {
      logic       imm20;      // sign bit
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;         // link register
      logic [6:0] opcode;
   } jal_fmt_t;

   // C.J lives in the low halfword only
   typedef struct packed {
      logic [15:0] unused;    // next parcel, not decoded here
      logic [2:0]  funct3;
      logic [10:0] imm;       // scrambled imm[11:1]
      logic [1:0]  quadrant;
   } cj_fmt_t;

   // one retired word, seen either as JAL or as C.J
   typedef union packed {
      jal_fmt_t jal;
      cj_fmt_t  cj;
   } rv_instr_u;

endpackage

//--- logic/jtb_update_if.sv
interface jtb_update_if;
   import predictor_pkg::*;

   logic                    update;     // write JTB entry, one cycle strobe
   logic                    invalidate; // clear valid bit of entry
   logic                    ualigc;     // jump is rvc at odd halfword
   logic [JTB_OFFSET_W-1:0] offset;     // signed halfword offset
   logic [31:0]             jump_add;   // word address of the jump

   modport decoder (
      output update,
      output invalidate,
      output ualigc,
      output offset,
      output jump_add
   );

   modport predictor (
      input update,
      input invalidate,
      input ualigc,
      input offset,
      input jump_add
   );

endinterface

//--- logic/jump_offset_decode.sv
module jump_offset_decode (
   input  logic                   retire_valid_i, // retired instr on the bus
   input  rv_instr_pkg::rv_instr_u retire_instr_i, // retired instr word
   input  logic [31:0]            retire_add_i,   // byte address of instr
   input  logic                   invalidate_i,   // drop JTB entry for address
   jtb_update_if.decoder          upd             // training side of JTB
);
   import rv_instr_pkg::*;
   import predictor_pkg::*;

   logic                    compressed;           // quadrant says 16-bit instr
   logic                    is_jal;
   logic                    is_cj;
   logic [10:0]             cj_imm;               // descrambled imm[11:1]
   logic [JTB_OFFSET_W-1:0] jal_off;
   logic [JTB_OFFSET_W-1:0] cj_off;

   assign compressed = (retire_instr_i.cj.quadrant != QUAD_FULL);

   // quadrant picks the view of the word
   assign is_jal = !compressed && (retire_instr_i.jal.opcode == OPC_JAL);
   assign is_cj  = compressed && (retire_instr_i.cj.quadrant == CJ_QUADRANT)
                  && (retire_instr_i.cj.funct3 == CJ_FUNCT3);

   // J-type immediate already in halfwords, imm[20:1]
   assign jal_off = {retire_instr_i.jal.imm20,
                     retire_instr_i.jal.imm19_12,
                     retire_instr_i.jal.imm11,
                     retire_instr_i.jal.imm10_1};

   // C.J field order is imm[11|4|9:8|10|6|7|3:1|5]
   assign cj_imm = {retire_instr_i.cj.imm[10],   // imm[11]
                    retire_instr_i.cj.imm[6],    // imm[10]
                    retire_instr_i.cj.imm[8:7],  // imm[9:8]
                    retire_instr_i.cj.imm[4],    // imm[7]
                    retire_instr_i.cj.imm[5],    // imm[6]
                    retire_instr_i.cj.imm[0],    // imm[5]
                    retire_instr_i.cj.imm[9],    // imm[4]
                    retire_instr_i.cj.imm[3:1]}; // imm[3:1]

   assign cj_off = {{(JTB_OFFSET_W-11){cj_imm[10]}}, cj_imm}; // sign extend

   // Only real jumps train the buffer.
   assign upd.update     = retire_valid_i && (is_jal || is_cj);
   assign upd.invalidate = invalidate_i;                   // no qualification
   assign upd.offset     = is_cj ? cj_off : jal_off;
   assign upd.ualigc     = is_cj && retire_add_i[1];       // rvc in upper half
   assign upd.jump_add   = {retire_add_i[31:2], 2'b00};    // word address

endmodule

//--- logic/jtb_storage.sv
module jtb_storage #(
   parameter int ENTRIES = predictor_pkg::JTB_ENTRIES, // number of entries
   parameter int WIDTH   = predictor_pkg::JTB_ENTRY_W  // bits per entry
) (
   input  logic                       s_clk_i,
   input  logic                       rst_n_i,      // clears all valid bits
   input  logic                       we_i,         // write entry, set valid
   input  logic                       invalidate_i, // clear valid at waddr_i
   input  logic [$clog2(ENTRIES)-1:0] waddr_i,
   input  logic [WIDTH-1:0]           wdata_i,
   input  logic [$clog2(ENTRIES)-1:0] raddr_i,
   output logic [WIDTH-1:0]           rdata_o,      // entry data, unqualified
   output logic                       rvalid_o      // valid bit at raddr_i
);

   logic [ENTRIES-1:0] valid_q;          // one flag per entry
   logic [ENTRIES-1:0] valid_sel;        // one-hot of waddr_i
   logic [ENTRIES-1:0] valid_d;
   logic [WIDTH-1:0]   mem_q [ENTRIES];  // entry payload

   assign valid_sel = {{(ENTRIES-1){1'b0}}, 1'b1} << waddr_i;

   // invalidate beats update on the flag
   always_comb begin
      valid_d = valid_q;
      if (invalidate_i) begin
         valid_d = valid_q & ~valid_sel;
      end else if (we_i) begin
         valid_d = valid_q | valid_sel;
      end
   end

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;
      end else begin
         valid_q <= valid_d;
      end
   end

   // payload written regardless of invalidate
   always_ff @(posedge s_clk_i) begin
      if (we_i) begin
         mem_q[waddr_i] <= wdata_i;
      end
   end

   assign rdata_o  = mem_q[raddr_i];   // async read port
   assign rvalid_o = valid_q[raddr_i];

endmodule

//--- logic/jump_predictor.sv
module jump_predictor (
   input  logic          s_clk_i,
   input  logic          rst_n_i,
   input  logic [30:0]   fetch_add_i,   // halfword address of the fetch
   jtb_update_if.predictor upd,         // training from retire
   output logic          s_pred_jump_o, // jump predicted at fetch_add_i
   output logic [31:0]   s_pred_add_o,  // predicted target, byte address
   output logic          s_ualigc_o     // predicted jump is unaligned rvc
);
   import predictor_pkg::*;

   logic [JTB_INDEX_W-1:0]  upd_index;    // slot of the retired jump
   logic [JTB_TAG_W-1:0]    upd_tag;
   logic [JTB_ENTRY_W-1:0]  upd_entry;    // packed {tag, ualigc, offset}
   logic [JTB_INDEX_W-1:0]  pred_index;   // slot of the fetch word
   logic [JTB_ENTRY_W-1:0]  pred_entry;
   logic                    pred_valid;
   logic [JTB_TAG_W-1:0]    pred_tag;     // stored tag
   logic                    pred_ualigc;  // stored flag
   logic [JTB_OFFSET_W-1:0] pred_offset;  // stored halfword offset
   logic                    tag_match;
   logic [30:0]             target_hw;    // target in halfwords

   // update side
   assign upd_index = upd.jump_add[JTB_INDEX_W+1:2];
   assign upd_tag   = upd.jump_add[31-JTB_SHARED:JTB_INDEX_W+2];
   assign upd_entry = {upd_tag, upd.ualigc, upd.offset};

   jtb_storage #(
      .ENTRIES (JTB_ENTRIES),
      .WIDTH   (JTB_ENTRY_W)
   ) u_jtb_storage (
      .s_clk_i      (s_clk_i),
      .rst_n_i      (rst_n_i),
      .we_i         (upd.update),
      .invalidate_i (upd.invalidate),
      .waddr_i      (upd_index),
      .wdata_i      (upd_entry),
      .raddr_i      (pred_index),
      .rdata_o      (pred_entry),
      .rvalid_o     (pred_valid)
   );

   // prediction side, halfword address so index starts at bit 1
   assign pred_index  = fetch_add_i[JTB_INDEX_W:1];
   assign {pred_tag, pred_ualigc, pred_offset} = pred_entry;
   assign tag_match   = (pred_tag == fetch_add_i[30-JTB_SHARED:JTB_INDEX_W+1]);

   // odd halfword fetch only hits an entry trained on an unaligned rvc jump
   assign s_pred_jump_o = pred_valid && tag_match && (!fetch_add_i[0] || pred_ualigc);

   // jump address rebuilt from the fetch word plus the stored flag
   assign target_hw = {fetch_add_i[30:1], pred_ualigc}
                    + {{(31-JTB_OFFSET_W){pred_offset[JTB_OFFSET_W-1]}}, pred_offset};

   assign s_pred_add_o = {target_hw, 1'b0};  // driven on a miss too
   assign s_ualigc_o   = pred_ualigc;

endmodule

//--- logic/jump_predict_unit.sv
module jump_predict_unit (
   input  logic        s_clk_i,
   input  logic        rst_n_i,        // async, active low
   input  logic        retire_valid_i, // retired instr presented
   input  logic [31:0] retire_instr_i, // retired instr word
   input  logic [31:0] retire_add_i,   // byte address of retired instr
   input  logic        invalidate_i,   // clear JTB entry for retire_add_i
   input  logic [30:0] fetch_add_i,    // halfword fetch address
   output logic        pred_jump_o,    // taken prediction
   output logic [31:0] pred_add_o,     // predicted target
   output logic        pred_ualigc_o   // target instr is unaligned rvc
);

   jtb_update_if u_jtb_update_if ();   // decoder to predictor training path

   // retire side, builds the training strobes
   jump_offset_decode u_jump_offset_decode (
      .retire_valid_i (retire_valid_i),
      .retire_instr_i (retire_instr_i),
      .retire_add_i   (retire_add_i),
      .invalidate_i   (invalidate_i),
      .upd            (u_jtb_update_if.decoder)
   );

   // fetch side lookup and JTB
   jump_predictor u_jump_predictor (
      .s_clk_i       (s_clk_i),
      .rst_n_i       (rst_n_i),
      .fetch_add_i   (fetch_add_i),
      .upd           (u_jtb_update_if.predictor),
      .s_pred_jump_o (pred_jump_o),
      .s_pred_add_o  (pred_add_o),
      .s_ualigc_o    (pred_ualigc_o)
   );

endmodule

//--- verification/jump_predict_unit_sva.sv
module jump_predict_unit_sva (
   input logic        s_clk_i,
   input logic        rst_n_i,
   input logic [30:0] fetch_add_i,   // halfword fetch address
   input logic        pred_jump_i,
   input logic [31:0] pred_add_i,
   input logic        pred_ualigc_i
);

   // valid bits held clear
   no_jump_in_reset: assert property (@(posedge s_clk_i) !rst_n_i |-> !pred_jump_i)
      else $error("jump predicted while reset is asserted");

   target_even: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      pred_add_i[0] == 1'b0)
      else $error("predicted target has bit 0 set");

   odd_fetch_ualigc: assert property (@(posedge s_clk_i) disable iff (!rst_n_i)
      (pred_jump_i && fetch_add_i[0]) |-> pred_ualigc_i)
      else $error("hit on odd halfword without unaligned flag");

endmodule

bind jump_predict_unit jump_predict_unit_sva u_jump_predict_unit_sva (
   .s_clk_i       (s_clk_i),
   .rst_n_i       (rst_n_i),
   .fetch_add_i   (fetch_add_i),
   .pred_jump_i   (pred_jump_o),
   .pred_add_i    (pred_add_o),
   .pred_ualigc_i (pred_ualigc_o)
);

//--- verification/tb_jump_predict_unit.sv
module tb_jump_predict_unit;

   localparam int          CLK_PERIOD     = 40;
   localparam int          RESET_CYCLES   = 16;
   localparam int          MAX_VECTORS    = 64;
   localparam int          VEC_WORDS      = 6;    // words per golden line
   localparam logic [31:0] CMD_RETIRE     = 32'd1;
   localparam logic [31:0] CMD_INVALIDATE = 32'd2;
   localparam logic [31:0] CMD_LOOKUP     = 32'd3;

   logic        s_clk;
   logic        rst_n;
   logic        retire_valid;
   logic [31:0] retire_instr;
   logic [31:0] retire_add;
   logic        invalidate;
   logic [30:0] fetch_add;      // halfword address
   logic        pred_jump;
   logic [31:0] pred_add;
   logic        pred_ualigc;

   logic [31:0] golden_mem [0:VEC_WORDS*MAX_VECTORS-1];
   int          vector_count;
   int          check_count;
   int          value_errors;
   int          other_errors;
   logic        vectors_loaded;
   logic [15:0] lfsr_state;     // idle gap source

   jump_predict_unit u_jump_predict_unit (
      .s_clk_i        (s_clk),
      .rst_n_i        (rst_n),
      .retire_valid_i (retire_valid),
      .retire_instr_i (retire_instr),
      .retire_add_i   (retire_add),
      .invalidate_i   (invalidate),
      .fetch_add_i    (fetch_add),
      .pred_jump_o    (pred_jump),
      .pred_add_o     (pred_add),
      .pred_ualigc_o  (pred_ualigc)
   );

   initial begin
      s_clk = 1'b0;
      forever #(CLK_PERIOD/2) s_clk = ~s_clk;
   end

   // 16-bit galois, taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] state);
      lfsr_next = {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
   endfunction

   task automatic take_bits(input int n, output int value);
      int i;
      value = 0;
      for (i = 0; i < n; i++) begin
         value      = (value << 1) | lfsr_state[0]; // one step per bit
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic logic known_command(input logic [31:0] cmd);
      known_command = (cmd === CMD_RETIRE) || (cmd === CMD_INVALIDATE)
                      || (cmd === CMD_LOOKUP);
   endfunction

   task automatic idle_gap();
      int gap;
      take_bits(2, gap);                  // 0..3 idle cycles
      repeat (gap) begin
         @(posedge s_clk);
         retire_valid <= 1'b0;
         invalidate   <= 1'b0;
      end
   endtask

   task automatic apply_vector(input int v);
      logic [31:0] cmd;
      logic [31:0] addr;
      cmd  = golden_mem[VEC_WORDS*v];
      addr = golden_mem[VEC_WORDS*v+2];
      @(posedge s_clk);
      retire_valid <= (cmd == CMD_RETIRE);   // one cycle strobes
      invalidate   <= (cmd == CMD_INVALIDATE);
      if (cmd == CMD_LOOKUP) begin
         fetch_add <= addr[31:1];
      end else begin
         retire_instr <= golden_mem[VEC_WORDS*v+1];
         retire_add   <= addr;
      end
   endtask

   task automatic check_lookup(input int v);
      logic        exp_jump;
      logic [31:0] exp_target;
      logic        exp_ualigc;
      exp_jump   = golden_mem[VEC_WORDS*v+3][0];
      exp_target = golden_mem[VEC_WORDS*v+4];
      exp_ualigc = golden_mem[VEC_WORDS*v+5][0];
      @(negedge s_clk);                   // outputs settled
      check_count++;
      assert (pred_jump === exp_jump) else begin
         value_errors++;
         $display("error at %0t: pred_jump_o is %b, expected %b", $time, pred_jump, exp_jump);
      end
      // target and flag only meaningful on a hit
      if (exp_jump) begin
         assert (pred_add === exp_target) else begin
            value_errors++;
            $display("error at %0t: pred_add_o is %h, expected %h",
                     $time, pred_add, exp_target);
         end
         assert (pred_ualigc === exp_ualigc) else begin
            value_errors++;
            $display("error at %0t: pred_ualigc_o is %b, expected %b",
                     $time, pred_ualigc, exp_ualigc);
         end
      end
   endtask

   initial begin
      rst_n          = 1'b0;
      retire_valid   = 1'b0;
      retire_instr   = '0;
      retire_add     = '0;
      invalidate     = 1'b0;
      fetch_add      = '0;
      check_count    = 0;
      value_errors   = 0;
      other_errors   = 0;
      vector_count   = 0;
      vectors_loaded = 1'b0;
      lfsr_state     = 16'd26967;
      $readmemh("verification/golden_jump_vectors.txt", golden_mem);
      while (vector_count < MAX_VECTORS && known_command(golden_mem[VEC_WORDS*vector_count]))
         vector_count++;
      vectors_loaded = 1'b1;
      if (vector_count == 0) begin
         other_errors++;
         $display("no test vectors could be read from the golden file");
      end
      repeat (RESET_CYCLES) @(posedge s_clk);
      rst_n <= 1'b1;
      for (int v = 0; v < vector_count; v++) begin
         idle_gap();
         apply_vector(v);
         if (golden_mem[VEC_WORDS*v] == CMD_LOOKUP) begin
            check_lookup(v);              // sees writes of the previous edge
         end
      end
      @(posedge s_clk);
      retire_valid <= 1'b0;
      invalidate   <= 1'b0;
      @(posedge s_clk);
      $display("checks %0d, value errors %0d, other errors %0d",
               check_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   // watchdog, four cycles per vector plus reset margin
   initial begin
      wait (vectors_loaded);
      repeat (vector_count*4 + 40) @(posedge s_clk);
      $display("timeout, the test sequence did not finish in %0d cycles", vector_count*4 + 40);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

//--- verification/golden_jump_vectors.txt
// cmd instr addr exp_jump exp_target exp_ualigc, all hex, addr and target are byte addresses
// cmd 1 retire, 2 invalidate, 3 lookup; target and ualigc are compared only on an expected hit
3 00000000 00001000 0 00000000 0
3 00000000 00001002 0 00000000 0
3 00000000 00002010 0 00000000 0
// jal ra, +0x100 at an aligned word
1 100000EF 00001008 0 00000000 0
3 00000000 00001008 1 00001108 0
3 00000000 0000100A 0 00000000 0
// jal x0, -0x20
1 FE1FF06F 00002010 0 00000000 0
3 00000000 00002010 1 00001FF0 0
// c.j +0x40 in the upper halfword
1 0000A081 00003006 0 00000000 0
3 00000000 00003006 1 00003046 1
3 00000000 00003004 1 00003046 1
// c.j -0x10 in the upper halfword
1 0000BFC5 0000401A 0 00000000 0
3 00000000 0000401A 1 0000400A 1
// same index, other tag; high bits above the tag are not compared
3 00000000 00005008 0 00000000 0
3 00000000 01001008 1 01001108 0
// addi and c.nop retire without touching the buffer
1 00100093 00001008 0 00000000 0
3 00000000 00001008 1 00001108 0
1 00000001 00003006 0 00000000 0
3 00000000 00003006 1 00003046 1
// invalidate, then retrain
2 00000000 00001008 0 00000000 0
3 00000000 00001008 0 00000000 0
3 00000000 00002010 1 00001FF0 0
1 100000EF 00001008 0 00000000 0
3 00000000 00001008 1 00001108 0

//--- vlog.f
logic/predictor_pkg.sv
logic/rv_instr_pkg.sv
logic/jtb_update_if.sv
logic/jump_offset_decode.sv
logic/jtb_storage.sv
logic/jump_predictor.sv
logic/jump_predict_unit.sv
verification/jump_predict_unit_sva.sv
verification/tb_jump_predict_unit.sv

//--- Bender.yml
package:
  name: jump_predict_unit

sources:
  - logic/predictor_pkg.sv
  - logic/rv_instr_pkg.sv
  - logic/jtb_update_if.sv
  - logic/jump_offset_decode.sv
  - logic/jtb_storage.sv
  - logic/jump_predictor.sv
  - logic/jump_predict_unit.sv
  - target: test
    files:
      - verification/jump_predict_unit_sva.sv
      - verification/tb_jump_predict_unit.sv
